//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = colorMapperTb
FILELIST = list.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJDIR)

//--- list.f
src/pixelPkg.sv
src/tileMap.sv
src/tileShader.sv
src/spriteHit.sv
src/pixelMixer.sv
src/colorMapper.sv
sim/clockGen.sv
sim/colorMapper_asserts.sv
sim/colorMapperTb.sv

//--- sim/clockGen.sv
// Testbench clock and power-on reset generator
`timescale 1ns/1ps

module clockGen (
	output logic Clk,
	output logic reset
);
	localparam int halfPeriod  = 10;  // 20 ns period
	localparam int resetCycles = 5;

	initial begin
		Clk = 1'b0;
		forever #halfPeriod Clk = ~Clk;
	end

	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge Clk);
		reset <= 1'b0;
	end

endmodule

//--- sim/colorMapperTb.sv
// Directed and random tests of the color pipeline against a reference color model
`timescale 1ns/1ps

module colorMapperTb;
	import pixelPkg::*;

	localparam int          latency        = 2;
	localparam int          resetTimeout   = 50;
	localparam int          watchdogCycles = 20000;
	localparam int          coordRange     = 1 << coordWidth;
	localparam int unsigned randSeed       = 90383;
	localparam pixelPosT    parkPos        = '{x: 10'd700, y: 10'd500};  // Off screen

	logic      Clk;
	logic      reset;
	logic      blank;
	pixelPosT  drawPos;
	gameStateT gameState;
	pixelPosT  player1Pos;
	pixelPosT  player2Pos;
	pixelPosT  bombPos;
	logic      bombArmed;
	mapWriteT  mapWrite;
	rgbT       rgb;

	tileKindT mapModel [mapSize];  // Testbench copy of the playfield
	int       errorCount;
	int       checkCount;

	clockGen clockGen_inst (.Clk(Clk), .reset(reset));

	colorMapper colorMapper_inst (
		.Clk        (Clk),
		.reset      (reset),
		.blank      (blank),
		.drawPos    (drawPos),
		.gameState  (gameState),
		.player1Pos (player1Pos),
		.player2Pos (player2Pos),
		.bombPos    (bombPos),
		.bombArmed  (bombArmed),
		.mapWrite   (mapWrite),
		.rgb        (rgb)
	);

	bind colorMapper colorMapper_asserts colorMapper_asserts_inst (
		.Clk   (Clk),
		.reset (reset),
		.blank (blank),
		.rgb   (rgb)
	);

	// ------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------
	function automatic pixelPosT pixAt(input int x, input int y);
		pixelPosT p;
		p.x = coordWidth'(x);  // Negative values wrap
		p.y = coordWidth'(y);
		return p;
	endfunction

	function automatic pixelPosT tilePix(input int index, input int offX, input int offY);
		return pixAt((index % mapCols) * tileSize + offX, (index / mapCols) * tileSize + offY);
	endfunction

	// Distance measured around the coordinate ring
	function automatic logic insideBox(input pixelPosT pix, input pixelPosT obj,
		input int w, input int h);
		int dx;
		int dy;
		dx = (int'(pix.x) - int'(obj.x) + coordRange) % coordRange;
		dy = (int'(pix.y) - int'(obj.y) + coordRange) % coordRange;
		return (dx < w) && (dy < h);
	endfunction

	function automatic rgbT modelColor();
		int       index;
		int       offX;
		int       offY;
		tileKindT kind;
		rgbT      tileRgb;
		logic     isSolid;
		index   = (int'(drawPos.y) / tileSize) * mapCols + int'(drawPos.x) / tileSize;
		offX    = int'(drawPos.x) % tileSize;
		offY    = int'(drawPos.y) % tileSize;
		kind    = (index < mapSize) ? mapModel[index] : tileEmpty;
		isSolid = (kind == tileWall) || (kind == tileBrick);
		case (kind)
			tileWall: tileRgb = (offX == 0 || offX == tileSize - 1 || offY == 0 ||
				offY == tileSize - 1) ? colorWallEdge : colorWallFace;
			tileBrick:   tileRgb = (offY % 8 == 0) ? colorMortar : colorBrick;
			tileSpeedUp: tileRgb = colorSpeedUp;
			tileBombUp:  tileRgb = colorBombUp;
			default:     tileRgb = colorSky;
		endcase
		if (!blank || gameState == statePause) return colorBlack;
		if (isSolid) return tileRgb;
		if (insideBox(drawPos, player1Pos, playerWidth, playerHeight)) return colorPlayer1;
		if (insideBox(drawPos, player2Pos, playerWidth, playerHeight)) return colorPlayer2;
		if (bombArmed && insideBox(drawPos, bombPos, bombWidth, bombHeight)) return colorBomb;
		return tileRgb;
	endfunction

	// ------------------------------------------------------------
	// Drivers and the pixel check
	// ------------------------------------------------------------
	task automatic waitForReset();
		int cycles;
		cycles = 0;
		do begin
			@(posedge Clk);
			cycles++;
		end while (reset === 1'b1 && cycles < resetTimeout);
		if (reset !== 1'b0) begin
			errorCount++;
			$display("Reset did not fall within %0d cycles", resetTimeout);
		end
	endtask

	task automatic writeTile(input int index, input tileKindT newKind);
		@(posedge Clk);
		mapWrite <= '{valid: 1'b1, index: tileIndexWidth'(index), kind: newKind};
		@(posedge Clk);
		mapWrite.valid <= 1'b0;
		if (index < mapSize) begin
			mapModel[index] = newKind;  // Out of range writes are dropped
		end
	endtask

	task automatic placeSprites(input pixelPosT p1, input pixelPosT p2, input pixelPosT bomb,
		input logic armed);
		@(posedge Clk);
		player1Pos <= p1;
		player2Pos <= p2;
		bombPos    <= bomb;
		bombArmed  <= armed;
	endtask

	task automatic setGameState(input gameStateT st);
		@(posedge Clk);
		gameState <= st;
	endtask

	task automatic checkPixel(input pixelPosT pos, input logic vis);
		rgbT expected;
		@(posedge Clk);
		drawPos <= pos;
		blank   <= vis;
		// Input register, then output register
		for (int i = 0; i < latency; i++) begin
			@(posedge Clk);
		end
		@(negedge Clk);
		expected = modelColor();
		checkCount++;
		assert (rgb == expected)
		else begin
			errorCount++;
			$display("ERROR rgb at x=%0d y=%0d: expected %06h, actual %06h",
				pos.x, pos.y, expected, rgb);
		end
	endtask

	// ------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------
	task automatic emptyMapTest();
		checkPixel(pixAt(0, 0), 1'b1);
		checkPixel(pixAt(639, 479), 1'b1);
		checkPixel(pixAt(317, 200), 1'b1);
		checkPixel(pixAt(100, 100), 1'b0);  // Blanked
		checkPixel(pixAt(639, 0), 1'b0);
	endtask

	task automatic wallBrickTest();
		writeTile(43, tileWall);
		writeTile(86, tileBrick);
		checkPixel(tilePix(43, 0, 12), 1'b1);
		checkPixel(tilePix(43, 31, 12), 1'b1);
		checkPixel(tilePix(43, 9, 0), 1'b1);
		checkPixel(tilePix(43, 9, 31), 1'b1);
		checkPixel(tilePix(43, 16, 16), 1'b1);
		for (int offY = 0; offY < tileSize; offY += 4) begin
			checkPixel(tilePix(86, 7, offY), 1'b1);  // Mortar rows and brick rows
		end
	endtask

	task automatic powerUpTest();
		writeTile(120, tileSpeedUp);
		writeTile(121, tileBombUp);
		writeTile(mapSize, tileWall);
		checkPixel(tilePix(120, 3, 3), 1'b1);
		checkPixel(tilePix(121, 28, 30), 1'b1);
		writeTile(120, tileEmpty);
		checkPixel(tilePix(120, 3, 3), 1'b1);
	endtask

	task automatic spritePriorityTest();
		placeSprites(pixAt(4, 322), pixAt(20, 325), pixAt(14, 340), 1'b1);
		checkPixel(pixAt(22, 345), 1'b1);  // All three overlap
		checkPixel(pixAt(25, 350), 1'b1);
		checkPixel(pixAt(15, 350), 1'b1);
		placeSprites(pixAt(4, 322), pixAt(20, 325), pixAt(14, 340), 1'b0);
		checkPixel(pixAt(15, 350), 1'b1);
		// Player over a wall tile
		writeTile(201, tileWall);
		placeSprites(pixAt(50, 330), parkPos, parkPos, 1'b0);
		checkPixel(pixAt(55, 335), 1'b1);
		checkPixel(pixAt(52, 351), 1'b1);
		checkPixel(pixAt(65, 335), 1'b1);
	endtask

	task automatic pauseTest();
		for (int pass = 0; pass < 2; pass++) begin
			setGameState(pass == 0 ? statePause : statePlay);
			checkPixel(pixAt(55, 335), 1'b1);
			checkPixel(pixAt(65, 335), 1'b1);
			checkPixel(tilePix(121, 5, 5), 1'b1);
		end
		placeSprites(parkPos, parkPos, parkPos, 1'b0);
	endtask

	function automatic pixelPosT nearPos(input pixelPosT pix);
		return pixAt(int'(pix.x) - int'($urandom_range(31, 0)),
			int'(pix.y) - int'($urandom_range(31, 0)));
	endfunction

	task automatic randomPixelTest();
		pixelPosT pix;
		for (int i = 0; i < 40; i++) begin
			writeTile(int'($urandom_range(mapSize + 19, 0)),
				tileKindT'(3'($urandom_range(4, 0))));
		end
		for (int i = 0; i < 300; i++) begin
			pix = pixAt(int'($urandom_range(mapCols * tileSize - 1, 0)),
				int'($urandom_range(mapRows * tileSize - 1, 0)));
			placeSprites(nearPos(pix), nearPos(pix), nearPos(pix), 1'($urandom_range(1, 0)));
			checkPixel(pix, 1'b1);
		end
	endtask

	// ------------------------------------------------------------
	// Main sequence and watchdog
	// ------------------------------------------------------------
	initial begin
		void'($urandom(randSeed));
		errorCount = 0;
		checkCount = 0;
		for (int i = 0; i < mapSize; i++) begin
			mapModel[i] = tileEmpty;
		end
		blank      <= 1'b0;
		drawPos    <= '0;
		gameState  <= statePlay;
		player1Pos <= parkPos;
		player2Pos <= parkPos;
		bombPos    <= parkPos;
		bombArmed  <= 1'b0;
		mapWrite   <= '0;
		waitForReset();
		emptyMapTest();
		wallBrickTest();
		powerUpTest();
		spritePriorityTest();
		pauseTest();
		randomPixelTest();
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		for (int i = 0; i < watchdogCycles; i++) begin
			@(posedge Clk);
		end
		$display("Run did not finish within %0d cycles", watchdogCycles);
		$display("** FAIL **");
		$finish;
	end

endmodule

//--- sim/colorMapper_asserts.sv
// Bound output checks of the color pipeline for blank, reset and unknown values
`timescale 1ns/1ps

module colorMapper_asserts (
	input logic          Clk,
	input logic          reset,
	input logic          blank,
	input pixelPkg::rgbT rgb
);
	import pixelPkg::*;

	// Blank low at one edge shows as black two edges later
	blankGivesBlack: assert property (@(posedge Clk) disable iff (reset)
		!$past(blank, 2) |-> rgb == colorBlack)
		else $error("rgb not black two cycles after blank was low");

	rgbKnown: assert property (@(posedge Clk) disable iff (reset)
		!$isunknown(rgb))
		else $error("rgb has unknown bits after reset");

	resetGivesBlack: assert property (@(posedge Clk)
		reset |=> rgb == colorBlack)
		else $error("rgb not black while reset is high");

endmodule

//--- src/colorMapper.sv
// Top level of the pixel color pipeline joining map, shader, sprite tests and mixer
`timescale 1ns/1ps

module colorMapper (
	input  logic                Clk,
	input  logic                reset,
	input  logic                blank,
	input  pixelPkg::pixelPosT  drawPos,
	input  pixelPkg::gameStateT gameState,
	input  pixelPkg::pixelPosT  player1Pos,
	input  pixelPkg::pixelPosT  player2Pos,
	input  pixelPkg::pixelPosT  bombPos,
	input  logic                bombArmed,
	input  pixelPkg::mapWriteT  mapWrite,
	output pixelPkg::rgbT       rgb
);
	import pixelPkg::*;

	tileLookupT lookup;
	tileColorT  tileColor;
	spriteHitsT hits;

	// Stage one background
	tileMap tileMap_inst (
		.Clk      (Clk),
		.reset    (reset),
		.drawPos  (drawPos),
		.mapWrite (mapWrite),
		.lookup   (lookup)
	);

	tileShader tileShader_inst (
		.lookup    (lookup),
		.tileColor (tileColor)
	);

	// Stage one sprites
	spriteHit spriteHit_inst (
		.Clk        (Clk),
		.reset      (reset),
		.drawPos    (drawPos),
		.player1Pos (player1Pos),
		.player2Pos (player2Pos),
		.bombPos    (bombPos),
		.bombArmed  (bombArmed),
		.hits       (hits)
	);

	// Stage two
	pixelMixer pixelMixer_inst (
		.Clk       (Clk),
		.reset     (reset),
		.blank     (blank),
		.gameState (gameState),
		.tileColor (tileColor),
		.hits      (hits),
		.rgb       (rgb)
	);

endmodule

//--- src/pixelMixer.sv
// Layer priority, pause and blank handling, and the output color register
`timescale 1ns/1ps

module pixelMixer (
	input  logic                 Clk,
	input  logic                 reset,
	input  logic                 blank,
	input  pixelPkg::gameStateT  gameState,
	input  pixelPkg::tileColorT  tileColor,
	input  pixelPkg::spriteHitsT hits,
	output pixelPkg::rgbT        rgb
);
	import pixelPkg::*;

	logic      blankQ;
	gameStateT stateQ;
	rgbT       colorNext;

	// ------------------------------------------------------------
	// Line up scan levels with stage one
	// ------------------------------------------------------------
	always_ff @(posedge Clk) begin
		if (reset) begin
			blankQ <= 1'b0;  // Holds output black for two cycles
			stateQ <= statePlay;
		end else begin
			blankQ <= blank;
			stateQ <= gameState;
		end
	end

	// ------------------------------------------------------------
	// Priority select
	// ------------------------------------------------------------
	always_comb begin
		if (!blankQ || stateQ == statePause) begin
			colorNext = colorBlack;
		end else if (tileColor.solid) begin
			colorNext = tileColor.color;  // Wall or brick
		end else if (hits.player1) begin
			colorNext = colorPlayer1;
		end else if (hits.player2) begin
			colorNext = colorPlayer2;
		end else if (hits.bomb) begin
			colorNext = colorBomb;
		end else begin
			// Power-ups and sky
			colorNext = tileColor.color;
		end
	end

	always_ff @(posedge Clk) begin
		if (reset) begin
			rgb <= colorBlack;
		end else begin
			rgb <= colorNext;
		end
	end

endmodule

//--- src/pixelPkg.sv
// Screen and tile constants, tile and game state enums, pixel structs, fixed colors
package pixelPkg;

	// ------------------------------------------------------------
	// Screen and playfield geometry
	// ------------------------------------------------------------
	localparam int coordWidth     = 10;
	localparam int tileSize       = 32;
	localparam int tileShift      = 5;  // log2 of tileSize
	localparam int mapCols        = 20;
	localparam int mapRows        = 15;
	localparam int mapSize        = mapCols * mapRows;
	localparam int tileIndexWidth = 9;

	// Sprite boxes
	localparam int playerWidth  = 20;
	localparam int playerHeight = 27;
	localparam int bombWidth    = 15;
	localparam int bombHeight   = 18;

	// ------------------------------------------------------------
	// Enums
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		tileEmpty   = 3'd0,
		tileWall    = 3'd1,
		tileBrick   = 3'd2,
		tileSpeedUp = 3'd3,
		tileBombUp  = 3'd4
	} tileKindT;

	typedef enum logic {
		statePlay  = 1'b0,
		statePause = 1'b1
	} gameStateT;

	// ------------------------------------------------------------
	// Structs
	// ------------------------------------------------------------
	typedef struct packed {
		logic [coordWidth-1:0] x;
		logic [coordWidth-1:0] y;
	} pixelPosT;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgbT;

	typedef struct packed {
		logic                      valid;
		logic [tileIndexWidth-1:0] index;
		tileKindT                  kind;
	} mapWriteT;

	typedef struct packed {
		tileKindT             kind;
		logic [tileShift-1:0] offX;
		logic [tileShift-1:0] offY;
	} tileLookupT;

	typedef struct packed {
		rgbT  color;
		logic solid;  // Drawn over sprites
	} tileColorT;

	typedef struct packed {
		logic player1;
		logic player2;
		logic bomb;
	} spriteHitsT;

	// ------------------------------------------------------------
	// Fixed colors
	// ------------------------------------------------------------
	localparam rgbT colorBlack    = rgbT'{8'h00, 8'h00, 8'h00};
	localparam rgbT colorSky      = rgbT'{8'h00, 8'ha2, 8'he8};
	localparam rgbT colorWallFace = rgbT'{8'hb0, 8'hb0, 8'hb0};
	localparam rgbT colorWallEdge = rgbT'{8'h40, 8'h40, 8'h40};
	localparam rgbT colorBrick    = rgbT'{8'hb5, 8'h31, 8'h20};
	localparam rgbT colorMortar   = rgbT'{8'hff, 8'hcc, 8'hc5};
	localparam rgbT colorSpeedUp  = rgbT'{8'hf8, 8'h28, 8'h00};
	localparam rgbT colorBombUp   = rgbT'{8'hf8, 8'h78, 8'h00};
	localparam rgbT colorPlayer1  = rgbT'{8'he8, 8'h20, 8'h50};
	localparam rgbT colorPlayer2  = rgbT'{8'he0, 8'h18, 8'h98};
	localparam rgbT colorBomb     = rgbT'{8'h20, 8'h40, 8'h58};

endpackage

//--- src/spriteHit.sv
// Registered box tests of the current pixel against both players and the bomb
`timescale 1ns/1ps

module spriteHit (
	input  logic                 Clk,
	input  logic                 reset,
	input  pixelPkg::pixelPosT   drawPos,
	input  pixelPkg::pixelPosT   player1Pos,
	input  pixelPkg::pixelPosT   player2Pos,
	input  pixelPkg::pixelPosT   bombPos,
	input  logic                 bombArmed,
	output pixelPkg::spriteHitsT hits
);
	import pixelPkg::*;

	// Unsigned wrap makes pixels left of or above the box fail the test
	function automatic logic boxHit(
		input pixelPosT              pix,
		input pixelPosT              obj,
		input logic [coordWidth-1:0] boxW,
		input logic [coordWidth-1:0] boxH
	);
		logic [coordWidth-1:0] distX;
		logic [coordWidth-1:0] distY;
		distX = pix.x - obj.x;
		distY = pix.y - obj.y;
		return (distX < boxW) && (distY < boxH);
	endfunction

	spriteHitsT hitsNext;

	always_comb begin
		hitsNext.player1 = boxHit(drawPos, player1Pos,
			coordWidth'(playerWidth), coordWidth'(playerHeight));
		hitsNext.player2 = boxHit(drawPos, player2Pos,
			coordWidth'(playerWidth), coordWidth'(playerHeight));
		hitsNext.bomb    = bombArmed && boxHit(drawPos, bombPos,
			coordWidth'(bombWidth), coordWidth'(bombHeight));
	end

	always_ff @(posedge Clk) begin
		if (reset) begin
			hits <= '0;
		end else begin
			hits <= hitsNext;  // Stage one
		end
	end

endmodule

//--- src/tileMap.sv
// Playfield tile storage with a write strobe and registered pixel lookup
`timescale 1ns/1ps

module tileMap (
	input  logic                   Clk,
	input  logic                   reset,
	input  pixelPkg::pixelPosT     drawPos,
	input  pixelPkg::mapWriteT     mapWrite,
	output pixelPkg::tileLookupT   lookup
);
	import pixelPkg::*;

	tileKindT tiles [mapSize];

	logic [coordWidth-tileShift-1:0] tileRow;
	logic [coordWidth-tileShift-1:0] tileCol;
	logic [coordWidth-1:0]           tileIndex;  // Row * 20 + column
	tileKindT                        kindNow;

	assign tileRow   = drawPos.y[coordWidth-1:tileShift];
	assign tileCol   = drawPos.x[coordWidth-1:tileShift];
	assign tileIndex = coordWidth'(tileRow) * coordWidth'(mapCols) + coordWidth'(tileCol);

	// Off the playfield reads as empty
	assign kindNow = (tileIndex < coordWidth'(mapSize)) ?
		tiles[tileIndex[tileIndexWidth-1:0]] : tileEmpty;

	always_ff @(posedge Clk) begin
		if (reset) begin
			for (int i = 0; i < mapSize; i++) begin
				tiles[i] <= tileEmpty;
			end
		end else if (mapWrite.valid && mapWrite.index < tileIndexWidth'(mapSize)) begin
			tiles[mapWrite.index] <= mapWrite.kind;
		end
	end

	// Stage one lookup
	always_ff @(posedge Clk) begin
		lookup.kind <= kindNow;
		lookup.offX <= drawPos.x[tileShift-1:0];
		lookup.offY <= drawPos.y[tileShift-1:0];
	end

endmodule

//--- src/tileShader.sv
// Per-kind pattern shading of a tile pixel into a color and a solid flag
`timescale 1ns/1ps

module tileShader (
	input  pixelPkg::tileLookupT lookup,
	output pixelPkg::tileColorT  tileColor
);
	import pixelPkg::*;

	localparam logic [tileShift-1:0] lastOff = tileShift'(tileSize - 1);

	logic onEdge;
	logic onMortar;

	// One pixel border around a wall tile
	assign onEdge = (lookup.offX == '0) || (lookup.offX == lastOff) ||
		(lookup.offY == '0) || (lookup.offY == lastOff);

	// Mortar line every 8 rows
	assign onMortar = (lookup.offY[2:0] == 3'd0);

	always_comb begin
		tileColor.solid = 1'b0;
		tileColor.color = colorSky;
		case (lookup.kind)
			tileWall: begin
				tileColor.solid = 1'b1;
				if (onEdge) begin
					tileColor.color = colorWallEdge;
				end else begin
					tileColor.color = colorWallFace;
				end
			end
			tileBrick: begin
				tileColor.solid = 1'b1;
				if (onMortar) begin
					tileColor.color = colorMortar;
				end else begin
					tileColor.color = colorBrick;
				end
			end
			tileSpeedUp: begin
				tileColor.color = colorSpeedUp;
			end
			tileBombUp: begin
				tileColor.color = colorBombUp;
			end
			default: begin
				tileColor.color = colorSky;  // Empty
			end
		endcase
	end

endmodule
